/* bench/filter_model.svh */
// Functional FIR reference, included inside the testbench module; expects writes only while idle
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

longint model_line [fir_pkg::taps];
longint model_coeffs [fir_pkg::taps];

// Expected output values and the cycle of the input strobe that produced each one
int exp_value [$];
int exp_cycle [$];

// Round half up at the Q1.15 point, then clip to the signed sample range
function automatic int round_saturate(longint acc);
  longint half;
  longint scaled;
  longint max_out;
  longint min_out;
  half    = longint'(1) <<< (fir_pkg::frac_bits - 1);
  max_out = (longint'(1) <<< (fir_pkg::sample_w - 1)) - 1;
  min_out = -(longint'(1) <<< (fir_pkg::sample_w - 1));
  scaled  = (acc + half) >>> fir_pkg::frac_bits;
  if (scaled > max_out) begin
    return int'(max_out);
  end
  if (scaled < min_out) begin
    return int'(min_out);
  end
  return int'(scaled);
endfunction

task automatic model_reset();
  for (int i = 0; i < fir_pkg::taps; i++) begin
    model_line[i]   = 0;
    model_coeffs[i] = longint'(fir_pkg::default_coeffs[i]);
  end
  exp_value.delete();
  exp_cycle.delete();
endtask

task automatic model_write(int addr, int value);
  model_coeffs[addr] = longint'(value);
endtask

// Newest sample sits at tap 0, matching the order the coefficients are listed in
task automatic model_accept(int sample, int strobe);
  longint acc;
  for (int i = fir_pkg::taps - 1; i > 0; i--) begin
    model_line[i] = model_line[i-1];
  end
  model_line[0] = longint'(sample);
  acc = 0;
  for (int i = 0; i < fir_pkg::taps; i++) begin
    acc = acc + model_line[i] * model_coeffs[i];
  end
  exp_value.push_back(round_saturate(acc));
  exp_cycle.push_back(strobe);
endtask

`endif

/* bench/filter_tb.sv */
// Drives filter_top from a row table; coefficient writes happen only between rows while idle
module filter_tb;
  timeunit 1ns;
  timeprecision 100ps;

  `include "filter_model.svh"

  localparam int n_rows      = 7;
  localparam int set_default = 0;
  localparam int set_custom  = 1;
  localparam int set_max     = 2;
  localparam int stim_impulse = 0;
  localparam int stim_random  = 1;
  localparam int stim_full    = 2;
  localparam int stim_gapped  = 3;

  logic                                clk;
  logic                                reset;
  logic signed [fir_pkg::sample_w-1:0] data_in;
  logic                                valid_in;
  logic                                coeff_we;
  logic [fir_pkg::coeff_addr_w-1:0]    coeff_addr;
  logic signed [fir_pkg::coeff_w-1:0]  coeff_wdata;
  logic signed [fir_pkg::sample_w-1:0] data_out;
  logic                                valid_out;
  logic                                overflow;

  int    cycle_count = 0;
  int    mismatch_errors = 0;
  int    other_errors = 0;
  int    cur_set;
  string cur_name = "startup";
  bit    overflow_seen = 1'b0;

  // Asymmetric and small enough that no random input can clip
  int custom_coeffs [fir_pkg::taps] = '{512, -1024, 1536, -2048, 2560, 3072, -256, 128,
                                        64, -32, 16, 8, -4, 2, 1, 4096};

  string row_name  [n_rows] = '{"impulse_default", "random_default", "impulse_custom",
                                "random_custom", "gapped_default", "saturate_max",
                                "random_after_saturate"};
  int    row_set   [n_rows] = '{set_default, set_default, set_custom, set_custom,
                                set_default, set_max, set_default};
  int    row_stim  [n_rows] = '{stim_impulse, stim_random, stim_impulse, stim_random,
                                stim_gapped, stim_full, stim_random};
  int    row_count [n_rows] = '{32, 64, 32, 48, 64, 40, 48};
  bit    row_ovf   [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  filter_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .data_in     (data_in),
    .valid_in    (valid_in),
    .coeff_we    (coeff_we),
    .coeff_addr  (coeff_addr),
    .coeff_wdata (coeff_wdata),
    .data_out    (data_out),
    .valid_out   (valid_out),
    .overflow    (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Gapped rows spend at most two cycles per sample; each row may add two resets and a write
  function automatic int total_cycles();
    int total;
    total = 16;
    for (int r = 0; r < n_rows; r++) begin
      total = total + row_count[r] * (row_stim[r] == stim_gapped ? 2 : 1);
      total = total + fir_pkg::latency + fir_pkg::taps + fir_pkg::taps + 2 * 17 + 4;
    end
    return total;
  endfunction

  function automatic int coeff_value(int set, int i);
    if (set == set_custom) begin
      return custom_coeffs[i];
    end
    if (set == set_max) begin
      return 32767;
    end
    return int'(fir_pkg::default_coeffs[i]);
  endfunction

  function automatic int random_sample();
    logic signed [fir_pkg::sample_w-1:0] r;
    r = 16'($urandom);
    return int'(r);
  endfunction

  // Impulse rows flush the line with zeros first so the response shows up in tap order
  function automatic int make_sample(int r, int k);
    if (row_stim[r] == stim_impulse) begin
      return (k == fir_pkg::taps) ? 32767 : 0;
    end
    if (row_stim[r] == stim_full) begin
      return (k < row_count[r] / 2) ? 32767 : -32768;
    end
    return random_sample();
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    model_reset();
    cur_set = set_default;
    if (valid_out !== 1'b0) begin
      $display("MISMATCH after_reset valid_out expected 0 actual %0b", valid_out);
      mismatch_errors++;
    end
    if (overflow !== 1'b0) begin
      $display("MISMATCH after_reset overflow expected 0 actual %0b", overflow);
      mismatch_errors++;
    end
    if (data_out !== '0) begin
      $display("MISMATCH after_reset data_out expected 0 actual %0d", data_out);
      mismatch_errors++;
    end
  endtask

  task automatic write_coeffs(int set);
    for (int i = 0; i < fir_pkg::taps; i++) begin
      @(posedge clk);
      #2;
      coeff_we    = 1'b1;
      coeff_addr  = 4'(i);
      coeff_wdata = 16'(coeff_value(set, i));
      model_write(i, coeff_value(set, i));
    end
    @(posedge clk);
    #2;
    coeff_we = 1'b0;
    cur_set  = set;
  endtask

  task automatic stream_row(int r);
    int sample;
    for (int k = 0; k < row_count[r]; k++) begin
      if (row_stim[r] == stim_gapped && $urandom_range(0, 1) == 1) begin
        @(posedge clk);
        #2;
        valid_in = 1'b0;
        data_in  = 16'($urandom);
      end
      sample = make_sample(r, k);
      @(posedge clk);
      #2;
      valid_in = 1'b1;
      data_in  = 16'(sample);
      model_accept(sample, cycle_count);
    end
    @(posedge clk);
    #2;
    valid_in = 1'b0;
    data_in  = '0;
  endtask

  task automatic finish_row(int r);
    if (exp_value.size() != 0) begin
      $display("Row %s ended with %0d outputs that never appeared", row_name[r],
               exp_value.size());
      other_errors++;
    end
    if (overflow !== row_ovf[r]) begin
      $display("MISMATCH %s overflow expected %0b actual %0b", row_name[r], row_ovf[r],
               overflow);
      mismatch_errors++;
    end
  endtask

  always @(negedge clk) begin : check_output
    int expected;
    int strobe;
    if (!reset && valid_out === 1'b1) begin
      if (exp_value.size() == 0) begin
        $display("Output in %s arrived with no sample outstanding", cur_name);
        other_errors++;
      end
      else begin
        expected = exp_value.pop_front();
        strobe   = exp_cycle.pop_front();
        if (int'(data_out) != expected) begin
          $display("MISMATCH %s data_out expected %0d actual %0d", cur_name, expected,
                   data_out);
          mismatch_errors++;
        end
        if (cycle_count - strobe != fir_pkg::latency) begin
          $display("MISMATCH %s latency expected %0d actual %0d", cur_name,
                   fir_pkg::latency, cycle_count - strobe);
          mismatch_errors++;
        end
      end
    end
  end

  // Once raised, the overflow flag may only drop through reset
  always @(negedge clk) begin : check_sticky
    if (reset) begin
      overflow_seen = 1'b0;
    end
    else begin
      if (overflow_seen && overflow !== 1'b1) begin
        $display("Overflow flag in %s fell without a reset", cur_name);
        other_errors++;
      end
      overflow_seen = (overflow === 1'b1);
    end
  end

  initial begin : watchdog
    #(2 * total_cycles() * 20);
    $display("Watchdog expired after %0d cycles without the run completing",
             2 * total_cycles());
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(32'hb50b));
    reset       = 1'b1;
    data_in     = '0;
    valid_in    = 1'b0;
    coeff_we    = 1'b0;
    coeff_addr  = '0;
    coeff_wdata = '0;
    apply_reset();
    for (int r = 0; r < n_rows; r++) begin
      cur_name = row_name[r];
      // The overflow flag is sticky, so rows that clip start and end with a reset
      if (row_ovf[r]) begin
        apply_reset();
      end
      if (row_set[r] != cur_set) begin
        write_coeffs(row_set[r]);
      end
      stream_row(r);
      repeat (fir_pkg::latency + fir_pkg::taps) @(posedge clk);
      #2;
      finish_row(r);
      if (row_ovf[r]) begin
        apply_reset();
      end
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end
    else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : filter_tb

/* common/fir_pkg.sv */
// Fixed 16-tap Q1.15 FIR; taps must stay a power of two so the adder tree halves evenly
package fir_pkg;

  localparam int taps         = 16;
  localparam int sample_w     = 16;
  localparam int coeff_w      = 16;
  localparam int prod_w       = sample_w + coeff_w;
  localparam int tree_levels  = 4;
  localparam int acc_w        = prod_w + tree_levels;
  localparam int frac_bits    = 15;
  localparam int coeff_addr_w = 4;

  // One cycle for the delay line, one for the products, the tree, then the output stage
  localparam int latency      = 2 + tree_levels + 1;

  // Symmetric low-pass set, the two centre taps carry 0.5 each
  localparam logic signed [coeff_w-1:0] default_coeffs [taps] = '{
    16'sd0,
    -16'sd8,
    -16'sd16,
    16'sd0,
    16'sd48,
    16'sd128,
    16'sd256,
    16'sd16384,
    16'sd16384,
    16'sd256,
    16'sd128,
    16'sd48,
    16'sd0,
    -16'sd16,
    -16'sd8,
    16'sd0
  };

endpackage : fir_pkg

/* filelist.f */
+incdir+bench
common/fir_pkg.sv
fir/fir_coeff_bank.sv
fir/fir_tap_mac.sv
fir/fir_adder_tree.sv
fir/fir_output_round.sv
rtl/filter_top.sv
bench/filter_tb.sv

/* fir/fir_adder_tree.sv */
// Four registered pairwise levels; each level widens by one bit so no sum can wrap
module fir_adder_tree (
  input  logic                                                clk,
  input  logic                                                reset,

  input  logic signed [fir_pkg::taps-1:0][fir_pkg::prod_w-1:0] products,
  input  logic                                                prod_valid,

  output logic signed [fir_pkg::acc_w-1:0]                    sum,
  output logic                                                sum_valid
);

  logic [fir_pkg::tree_levels-1:0] valid_sr;

  for (genvar l = 0; l < fir_pkg::tree_levels; l++) begin : level
    logic signed [fir_pkg::prod_w+l:0] node [fir_pkg::taps >> (l + 1)];

    if (l == 0) begin : g_leaf
      // Packed element selects are unsigned, so the products are cast back before extension
      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          for (int i = 0; i < (fir_pkg::taps >> 1); i++) begin
            node[i] <= '0;
          end
        end
        else begin
          for (int i = 0; i < (fir_pkg::taps >> 1); i++) begin
            node[i] <= $signed(products[2*i]) + $signed(products[2*i+1]);
          end
        end
      end
    end
    else begin : g_inner
      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          for (int i = 0; i < (fir_pkg::taps >> (l + 1)); i++) begin
            node[i] <= '0;
          end
        end
        else begin
          for (int i = 0; i < (fir_pkg::taps >> (l + 1)); i++) begin
            node[i] <= level[l-1].node[2*i] + level[l-1].node[2*i+1];
          end
        end
      end
    end
  end

  // Valid travels one level per edge alongside the data
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_sr <= '0;
    end
    else begin
      valid_sr <= {valid_sr[fir_pkg::tree_levels-2:0], prod_valid};
    end
  end

  assign sum       = level[fir_pkg::tree_levels-1].node[0];
  assign sum_valid = valid_sr[fir_pkg::tree_levels-1];

endmodule : fir_adder_tree

/* fir/fir_coeff_bank.sv */
// One coefficient written per strobe; a write during streaming mixes old and new taps in flight
module fir_coeff_bank (
  input  logic                                                clk,
  input  logic                                                reset,

  input  logic                                                coeff_we,
  input  logic        [fir_pkg::coeff_addr_w-1:0]             coeff_addr,
  input  logic signed [fir_pkg::coeff_w-1:0]                  coeff_wdata,

  output logic        [fir_pkg::taps-1:0][fir_pkg::coeff_w-1:0] coeffs
);

  // Reset restores the default low-pass response
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < fir_pkg::taps; i++) begin
        coeffs[i] <= fir_pkg::default_coeffs[i];
      end
    end
    else begin
      if (coeff_we) begin
        coeffs[coeff_addr] <= coeff_wdata;
      end
    end
  end

  // An unknown write value would poison every later output through the tree
  a_wdata_known : assert property (
    @(posedge clk) disable iff (reset)
    coeff_we |-> !$isunknown({coeff_addr, coeff_wdata})
  );

endmodule : fir_coeff_bank

/* fir/fir_output_round.sv */
// Round half up then clip to 16 bits; the overflow flag is sticky and only reset clears it
module fir_output_round (
  input  logic                               clk,
  input  logic                               reset,

  input  logic signed [fir_pkg::acc_w-1:0]   sum,
  input  logic                               sum_valid,

  output logic signed [fir_pkg::sample_w-1:0] data_out,
  output logic                               valid_out,
  output logic                               overflow
);

  logic signed [fir_pkg::acc_w-1:0]               rounded;
  logic signed [fir_pkg::acc_w-fir_pkg::frac_bits-1:0] shifted;
  logic        [fir_pkg::acc_w-fir_pkg::frac_bits-1:fir_pkg::sample_w-1] top_bits;
  logic                                           clip;
  logic signed [fir_pkg::sample_w-1:0]            clipped;

  assign rounded = sum + (fir_pkg::acc_w)'(1 << (fir_pkg::frac_bits - 1));
  assign shifted = rounded[fir_pkg::acc_w-1:fir_pkg::frac_bits];

  // The result fits only if every bit above the 16-bit sign matches that sign
  assign top_bits = shifted[fir_pkg::acc_w-fir_pkg::frac_bits-1:fir_pkg::sample_w-1];
  assign clip     = !((&top_bits) || !(|top_bits));

  always_comb begin
    if (!clip) begin
      clipped = shifted[fir_pkg::sample_w-1:0];
    end
    else if (shifted[fir_pkg::acc_w-fir_pkg::frac_bits-1]) begin
      clipped = {1'b1, {(fir_pkg::sample_w-1){1'b0}}};
    end
    else begin
      clipped = {1'b0, {(fir_pkg::sample_w-1){1'b1}}};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      data_out  <= '0;
      valid_out <= 1'b0;
      overflow  <= 1'b0;
    end
    else begin
      data_out  <= clipped;
      valid_out <= sum_valid;
      if (sum_valid && clip) begin
        overflow <= 1'b1;
      end
    end
  end

  // An unknown sum would leave both the clip decision and the overflow flag undefined
  a_sum_known : assert property (
    @(posedge clk) disable iff (reset)
    sum_valid |-> !$isunknown(sum)
  );

endmodule : fir_output_round

/* fir/fir_tap_mac.sv */
// Delay line moves only on valid samples; products are formed every cycle regardless of valid
module fir_tap_mac (
  input  logic                                                 clk,
  input  logic                                                 reset,

  input  logic signed [fir_pkg::sample_w-1:0]                  data_in,
  input  logic                                                 valid_in,
  input  logic        [fir_pkg::taps-1:0][fir_pkg::coeff_w-1:0] coeffs,

  output logic signed [fir_pkg::taps-1:0][fir_pkg::prod_w-1:0]  products,
  output logic                                                 prod_valid
);

  logic signed [fir_pkg::sample_w-1:0] line [fir_pkg::taps];
  logic                                line_valid;

  // Tap 0 holds the newest accepted sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < fir_pkg::taps; i++) begin
        line[i] <= '0;
      end
      line_valid <= 1'b0;
    end
    else begin
      line_valid <= valid_in;
      if (valid_in) begin
        line[0] <= data_in;
        for (int i = 1; i < fir_pkg::taps; i++) begin
          line[i] <= line[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < fir_pkg::taps; i++) begin
        products[i] <= '0;
      end
      prod_valid <= 1'b0;
    end
    else begin
      for (int i = 0; i < fir_pkg::taps; i++) begin
        products[i] <= line[i] * $signed(coeffs[i]);
      end
      prod_valid <= line_valid;
    end
  end

  // An unknown strobe would corrupt both the delay line and the valid pipeline
  a_valid_known : assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(valid_in)
  );

endmodule : fir_tap_mac

/* rtl/filter_top.sv */
// Streaming 16-tap FIR, seven cycles from input strobe to output pulse, no back-pressure
module filter_top (
  input  logic                                clk,
  input  logic                                reset,

  input  logic signed [fir_pkg::sample_w-1:0] data_in,
  input  logic                                valid_in,

  input  logic                                coeff_we,
  input  logic        [fir_pkg::coeff_addr_w-1:0] coeff_addr,
  input  logic signed [fir_pkg::coeff_w-1:0]  coeff_wdata,

  output logic signed [fir_pkg::sample_w-1:0] data_out,
  output logic                                valid_out,
  output logic                                overflow
);

  logic        [fir_pkg::taps-1:0][fir_pkg::coeff_w-1:0] coeffs;
  logic signed [fir_pkg::taps-1:0][fir_pkg::prod_w-1:0]  products;
  logic                                                 prod_valid;
  logic signed [fir_pkg::acc_w-1:0]                     sum;
  logic                                                 sum_valid;

  fir_coeff_bank coeff_bank_i (
    .clk         (clk),
    .reset       (reset),
    .coeff_we    (coeff_we),
    .coeff_addr  (coeff_addr),
    .coeff_wdata (coeff_wdata),
    .coeffs      (coeffs)
  );

  fir_tap_mac tap_mac_i (
    .clk        (clk),
    .reset      (reset),
    .data_in    (data_in),
    .valid_in   (valid_in),
    .coeffs     (coeffs),
    .products   (products),
    .prod_valid (prod_valid)
  );

  fir_adder_tree adder_tree_i (
    .clk        (clk),
    .reset      (reset),
    .products   (products),
    .prod_valid (prod_valid),
    .sum        (sum),
    .sum_valid  (sum_valid)
  );

  fir_output_round output_round_i (
    .clk       (clk),
    .reset     (reset),
    .sum       (sum),
    .sum_valid (sum_valid),
    .data_out  (data_out),
    .valid_out (valid_out),
    .overflow  (overflow)
  );

endmodule : filter_top

/* run_sim.sh */
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and checks the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module filter_tb -f filelist.f -o filter_sim

output=$(./obj_dir/filter_sim)
echo "$output"

if echo "$output" | grep -qF "All tests passed!"; then
  exit 0
fi
exit 1
